//--- list.f
design/nes_bus_pkg.sv
design/clock_enables.sv
design/dma_controller.sv
design/bus_arbiter.sv
design/read_data_mux.sv
design/nes_bus_top.sv
testbench/tb_nes_bus_assert.sv
testbench/tb_nes_bus.sv

//--- testbench/tb_nes_bus.sv
`timescale 1ns/1ps

module tb_nes_bus;
	import nes_bus_pkg::*;

	localparam int CYCLE_LIMIT = 1200 * 12 + 400; // CPU cycles of all tests plus margin

	logic clk, reset, cpu_rnw, dmc_trigger, prg_allow;
	logic [15:0] cpu_addr, dmc_addr, bus_addr;
	logic [7:0] cpu_dout, ppu_dout, apu_dout, mem_din, bus_dout, cpu_din;
	logic [4:0] joypad1_data, joypad2_data;
	logic [1:0] sys_type, joypad_clock;
	logic [2:0] joypad_out;
	logic cpu_ce, ppu_ce, cpu_reset, pause_cpu, dmc_ack, bus_read, bus_write, ppu_read, ppu_write;
	logic [15:0] lfsr = 16'd49183;
	logic [7:0] rand_table [256]; // Memory contents per offset, page folded in below
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int test_errors;

	nes_bus_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d clocks", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Memory answers one clock after the address appears
	always @(posedge clk) mem_din <= mem_byte(bus_addr);

	function automatic logic [7:0] mem_byte(input logic [15:0] addr);
		mem_byte = rand_table[addr[7:0]] ^ addr[15:8];
	endfunction

	// Galois LFSR, one step per bit taken
	function logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		rand_bits = r;
	endfunction

	task automatic expect_equal(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			$display("Check failed: %s", what);
			errors++;
		end
	endtask

	// One CPU bus cycle, returns at the negedge before the cycle's last edge
	task automatic cpu_cycle(input logic [15:0] addr, input logic rnw, input logic [7:0] data,
			input logic prg);
		@(posedge clk);
		cpu_addr  <= addr;
		cpu_rnw   <= rnw;
		cpu_dout  <= data;
		prg_allow <= prg;
		@(negedge clk);
		while (!cpu_ce) @(negedge clk);
	endtask

	task automatic report(input string name);
		int total;
		total = errors + u_dut.u_assert.fail_count;
		$display("Test %s: %0d errors", name, total - test_errors);
		test_errors = total;
	endtask

	// Sprite copy of one page, optionally with a sample DMA in the middle
	task automatic sprite_copy(input logic [7:0] page, input logic with_dmc);
		int writes;
		int acks;
		logic [7:0] exp_off;
		logic [7:0] last_byte;
		logic have_read;
		writes = 0;
		acks = 0;
		exp_off = 8'h00;
		have_read = 1'b0;
		cpu_cycle(SPRITE_DMA_REG, 1'b0, page, 1'b1);
		while (writes < 256) begin
			@(posedge clk);
			cpu_addr <= 16'h0000; // CPU keeps reading while stalled
			cpu_rnw  <= 1'b1;
			if (with_dmc && writes == 100 && acks == 0) dmc_trigger <= 1'b1;
			if (acks > 0) dmc_trigger <= 1'b0;
			@(negedge clk);
			while (!cpu_ce) @(negedge clk);
			if (dmc_ack) begin
				expect_equal("bus_addr", bus_addr, dmc_addr);
				expect_true(bus_read, "sample DMA cycle was not a read");
				acks++;
			end else if (bus_read && bus_addr[15:8] == page) begin
				expect_equal("bus_addr", bus_addr, {page, exp_off}); // Repeat reads keep offset
				last_byte = mem_byte({page, exp_off});
				expect_equal("cpu_din", cpu_din, last_byte);
				have_read = 1'b1;
			end else if (bus_write) begin
				expect_equal("bus_addr", bus_addr, OAM_DATA_REG);
				expect_true(have_read, "sprite write without a read before it");
				expect_equal("bus_dout", bus_dout, last_byte);
				have_read = 1'b0;
				exp_off++;
				writes++;
			end
		end
		@(negedge clk);
		expect_true(!pause_cpu, "pause_cpu still high after the last write");
		expect_equal("sample_acks", acks, with_dmc ? 1 : 0);
	endtask

	initial begin
		logic [7:0] prev_din;
		logic [7:0] wval;
		reset = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		cpu_rnw = 1'b1;
		dmc_trigger = 1'b0;
		dmc_addr = 16'hC123;
		ppu_dout = 8'h00;
		apu_dout = 8'h00;
		mem_din = 8'h00;
		prg_allow = 1'b1;
		joypad1_data = 5'h00;
		joypad2_data = 5'h00;
		sys_type = 2'b00; // NTSC throughout
		for (int i = 0; i < 256; i++) rand_table[i] = rand_bits(8);
		test_errors = 0;

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		expect_true(!pause_cpu && !dmc_ack && !bus_write, "outputs not idle after reset");
		while (!cpu_ce) @(negedge clk);
		expect_true(cpu_reset, "cpu_reset low before the first cpu_ce");
		@(negedge clk);
		expect_true(!cpu_reset, "cpu_reset did not fall after the first cpu_ce");
		repeat (40) @(negedge clk); // Divider spacing checked by bound assertions
		report("1 reset and clocks");

		sprite_copy(8'h03, 1'b0);
		report("2 sprite DMA");
		sprite_copy(8'h05, 1'b1);
		report("3 sample DMA inside sprite DMA");

		@(posedge clk);
		joypad1_data <= rand_bits(5);
		apu_dout <= rand_bits(8);
		ppu_dout <= rand_bits(8);
		cpu_cycle(16'h6000, 1'b1, 8'h00, 1'b1);
		prev_din = mem_byte(16'h6000);
		cpu_cycle(JOY1_REG, 1'b1, 8'h00, 1'b1);
		expect_equal("cpu_din", cpu_din, {prev_din[7:5], joypad1_data});
		cpu_cycle(APU_STATUS_REG, 1'b1, 8'h00, 1'b1);
		expect_equal("cpu_din", cpu_din, apu_dout);
		cpu_cycle(16'h2002, 1'b1, 8'h00, 1'b1);
		expect_equal("cpu_din", cpu_din, ppu_dout);
		cpu_cycle(16'h6000, 1'b1, 8'h00, 1'b1);
		expect_equal("cpu_din", cpu_din, mem_byte(16'h6000));
		prev_din = mem_byte(16'h6000);
		cpu_cycle(16'h7000, 1'b1, 8'h00, 1'b0); // Memory byte here differs from 0x6000
		expect_equal("cpu_din", cpu_din, prev_din); // Open bus keeps the last byte
		report("4 read sources");

		wval = rand_bits(8);
		cpu_cycle(JOY1_REG, 1'b0, wval, 1'b1);
		expect_equal("joypad_out", joypad_out, wval[2:0]);
		wval = ~wval; // Every strobe bit takes both levels
		cpu_cycle(JOY1_REG, 1'b0, wval, 1'b1);
		expect_equal("joypad_out", joypad_out, wval[2:0]);
		cpu_cycle(JOY1_REG, 1'b1, 8'h00, 1'b1);
		expect_equal("joypad_clock", joypad_clock, 2'b01);
		cpu_cycle(JOY2_REG, 1'b1, 8'h00, 1'b1);
		expect_equal("joypad_clock", joypad_clock, 2'b10);
		cpu_cycle(16'h2001, 1'b0, 8'h1E, 1'b1); // Window checked by bound assertion
		cpu_cycle(16'h0000, 1'b1, 8'h00, 1'b1);
		report("5 joypad port");

		errors += u_dut.u_assert.fail_count;
		$display("Checks: %0d, assertion failures: %0d, errors: %0d", checks,
			u_dut.u_assert.fail_count, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- testbench/tb_nes_bus_assert.sv
`timescale 1ns/1ps

module nes_bus_assert (
	input logic        clk,
	input logic        reset,
	input logic [1:0]  sys_type,
	input logic        cpu_ce,
	input logic        ppu_ce,
	input logic        cpu_reset,
	input logic        pause_cpu,
	input logic        dmc_ack,
	input logic        sprite_start,
	input logic [15:0] bus_addr,
	input logic [15:0] dmc_addr,
	input logic        bus_read,
	input logic        ppu_read,
	input logic        ppu_write,
	input logic [2:0]  joypad_out
);
	int fail_count = 0; // Read back by the testbench

	a_reset_idle: assert property (@(posedge clk) reset |=> !pause_cpu && !dmc_ack
		&& !ppu_write && joypad_out == 3'b000)
		else begin $error("outputs not idle after reset"); fail_count++; end

	// CPU held in reset until its first tick
	a_cpu_reset: assert property (@(posedge clk) disable iff (reset)
		cpu_ce && cpu_reset |=> !cpu_reset)
		else begin $error("cpu_reset did not fall"); fail_count++; end

	a_cpu_gap: assert property (@(posedge clk) disable iff (reset || sys_type[0])
		cpu_ce |=> !cpu_ce [*11] ##1 cpu_ce)
		else begin $error("cpu_ce not 12 clocks apart"); fail_count++; end

	a_ppu_gap: assert property (@(posedge clk) disable iff (reset || sys_type[0])
		ppu_ce |=> !ppu_ce [*3] ##1 ppu_ce)
		else begin $error("ppu_ce not 4 clocks apart"); fail_count++; end

	a_sprite_pause: assert property (@(posedge clk) disable iff (reset)
		cpu_ce && sprite_start |=> pause_cpu)
		else begin $error("pause_cpu did not rise on sprite DMA"); fail_count++; end

	a_dmc_bus: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> bus_read && bus_addr == dmc_addr)
		else begin $error("sample DMA cycle has wrong bus"); fail_count++; end

	// Stolen read lasts one CPU cycle
	a_dmc_one: assert property (@(posedge clk) disable iff (reset)
		dmc_ack && cpu_ce |=> !dmc_ack)
		else begin $error("dmc_ack longer than one CPU cycle"); fail_count++; end

	a_ppu_window: assert property (@(posedge clk) disable iff (reset)
		ppu_write |-> bus_addr >= 16'h2000 && bus_addr < 16'h4000)
		else begin $error("ppu_write outside the picture unit window"); fail_count++; end

	// Picture unit read strobe only for bus reads inside its window
	a_ppu_read_window: assert property (@(posedge clk) disable iff (reset)
		ppu_read |-> bus_read && bus_addr >= 16'h2000 && bus_addr < 16'h4000)
		else begin $error("ppu_read outside a picture unit read"); fail_count++; end

endmodule

bind nes_bus_top nes_bus_assert u_assert (.*);

//--- design/nes_bus_top.sv
`timescale 1ns/1ps

module nes_bus_top import nes_bus_pkg::*; #(
	parameter int CPU_DIV = DEFAULT_CPU_DIV,
	parameter int PPU_DIV = DEFAULT_PPU_DIV
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	input  logic        cpu_rnw,
	input  logic        dmc_trigger,
	input  logic [15:0] dmc_addr,
	input  logic [7:0]  ppu_dout,
	input  logic [7:0]  apu_dout,
	input  logic [7:0]  mem_din,
	input  logic        prg_allow,
	input  logic [4:0]  joypad1_data,
	input  logic [4:0]  joypad2_data,
	input  logic [1:0]  sys_type,
	output logic        cpu_ce,
	output logic        ppu_ce,
	output logic        cpu_reset,
	output logic        pause_cpu,
	output logic        dmc_ack,
	output logic [15:0] bus_addr,
	output logic [7:0]  bus_dout,
	output logic        bus_read,
	output logic        bus_write,
	output logic [7:0]  cpu_din,
	output logic        ppu_read,
	output logic        ppu_write,
	output logic [2:0]  joypad_out,
	output logic [1:0]  joypad_clock
);
	logic        odd_cycle, ppu_slot_read, ppu_slot_write;
	logic [15:0] dma_addr;
	logic        dma_enable, dma_read;
	logic [7:0]  dma_data;
	logic        sprite_start;
	logic        ppu_sel, apu_sel, joy1_sel, joy2_sel;

	clock_enables #(.CPU_DIV(CPU_DIV), .PPU_DIV(PPU_DIV)) u_clock_enables (
		.clk, .reset, .sys_type, .cpu_ce, .ppu_ce, .odd_cycle,
		.ppu_slot_read, .ppu_slot_write, .cpu_reset
	);

	// Read data loops back as the DMA source byte
	dma_controller u_dma_controller (
		.clk, .reset, .cpu_ce, .odd_cycle, .sprite_start, .cpu_rnw, .cpu_dout,
		.ram_data(cpu_din), .dmc_trigger, .dmc_addr, .dma_addr, .dma_enable,
		.dma_read, .dma_data, .dmc_ack, .pause_cpu
	);

	bus_arbiter u_bus_arbiter (
		.clk, .reset, .cpu_addr, .cpu_dout, .cpu_rnw, .dma_addr, .dma_enable,
		.dma_read, .dma_data, .ppu_slot_read, .ppu_slot_write, .bus_addr,
		.bus_dout, .bus_read, .bus_write, .sprite_start, .ppu_sel, .apu_sel,
		.joy1_sel, .joy2_sel, .ppu_read, .ppu_write, .joypad_out, .joypad_clock
	);

	read_data_mux u_read_data_mux (
		.clk, .reset, .bus_addr, .apu_sel, .ppu_sel, .joy1_sel, .joy2_sel,
		.joypad1_data, .joypad2_data, .apu_dout, .ppu_dout, .mem_din,
		.prg_allow, .cpu_din
	);

endmodule

//--- design/read_data_mux.sv
`timescale 1ns/1ps

module read_data_mux import nes_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] bus_addr,
	input  logic        apu_sel,
	input  logic        ppu_sel,
	input  logic        joy1_sel,
	input  logic        joy2_sel,
	input  logic [4:0]  joypad1_data,
	input  logic [4:0]  joypad2_data,
	input  logic [7:0]  apu_dout,
	input  logic [7:0]  ppu_dout,
	input  logic [7:0]  mem_din,
	input  logic        prg_allow,  // Memory drives the bus for this address
	output logic [7:0]  cpu_din
);
	logic [7:0] open_bus; // Last value seen on the data bus

	always_comb begin
		if (reset)
			cpu_din = 8'h00;
		else if (joy1_sel)
			cpu_din = {open_bus[7:5], joypad1_data}; // Pads drive only five bits
		else if (joy2_sel)
			cpu_din = {open_bus[7:5], joypad2_data};
		else if (bus_addr == APU_STATUS_REG)
			cpu_din = apu_dout;
		else if (apu_sel)
			cpu_din = open_bus; // Write-only audio registers
		else if (ppu_sel)
			cpu_din = ppu_dout;
		else if (prg_allow)
			cpu_din = mem_din;
		else
			cpu_din = open_bus; // Nothing answered
	end

	// Bus capacitance holds the previous value
	always_ff @(posedge clk) begin
		open_bus <= cpu_din;
	end

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import nes_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	input  logic        cpu_rnw,
	input  logic [15:0] dma_addr,
	input  logic        dma_enable,
	input  logic        dma_read,
	input  logic [7:0]  dma_data,
	input  logic        ppu_slot_read,
	input  logic        ppu_slot_write,
	output logic [15:0] bus_addr,
	output logic [7:0]  bus_dout,
	output logic        bus_read,
	output logic        bus_write,
	output logic        sprite_start,
	output logic        ppu_sel,
	output logic        apu_sel,
	output logic        joy1_sel,
	output logic        joy2_sel,
	output logic        ppu_read,
	output logic        ppu_write,
	output logic [2:0]  joypad_out,   // Strobe bits for both pads
	output logic [1:0]  joypad_clock  // One bit per pad
);
	bus_addr_u addr;
	logic [2:0] joy_latch;

	// DMA takes the bus whenever it asks
	assign addr.word = dma_enable ? dma_addr : cpu_addr;
	assign bus_addr  = addr.word;
	assign bus_dout  = dma_enable ? dma_data : cpu_dout;
	assign bus_read  = dma_enable ? dma_read : cpu_rnw;
	assign bus_write = !bus_read;

	// Window decode on the full word
	assign ppu_sel  = (addr.word >= PPU_LO) && (addr.word < PPU_HI);
	assign apu_sel  = (addr.word >= APU_LO) && (addr.word < APU_HI);
	assign joy1_sel = (addr.word == JOY1_REG);
	assign joy2_sel = (addr.word == JOY2_REG);

	assign sprite_start = bus_write && (addr.word == SPRITE_DMA_REG);

	// Picture unit only sees an access in its own dot
	assign ppu_read  = ppu_sel && bus_read && ppu_slot_read;
	assign ppu_write = ppu_sel && bus_write && ppu_slot_write;

	assign joypad_clock = {joy2_sel && bus_read, joy1_sel && bus_read};
	assign joypad_out   = joy_latch;

	always_ff @(posedge clk) begin
		if (reset)
			joy_latch <= 3'b000;
		else if (joy1_sel && bus_write)
			joy_latch <= bus_dout[2:0]; // Low three bits of the 0x4016 write
	end

endmodule

//--- design/dma_controller.sv
`timescale 1ns/1ps

module dma_controller import nes_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        cpu_ce,
	input  logic        odd_cycle,
	input  logic        sprite_start, // CPU write to 0x4014
	input  logic        cpu_rnw,      // CPU is in a read cycle
	input  logic [7:0]  cpu_dout,     // Page number on the start write
	input  logic [7:0]  ram_data,     // Read data returned by the bus
	input  logic        dmc_trigger,  // Sample DMA request level
	input  logic [15:0] dmc_addr,
	output logic [15:0] dma_addr,
	output logic        dma_enable,   // DMA owns the bus
	output logic        dma_read,     // 1 read, 0 write
	output logic [7:0]  dma_data,
	output logic        dmc_ack,
	output logic        pause_cpu
);
	// Bit 0 stalls the CPU, bit 1 means the copy owns the bus
	localparam logic [1:0] SPR_IDLE = 2'b00;
	localparam logic [1:0] SPR_PEND = 2'b01;
	localparam logic [1:0] SPR_RUN  = 2'b11;

	logic [1:0] spr_state;
	logic       dmc_pend;   // Sample read waiting for an even cycle
	bus_addr_u  src;        // Copy source, page fixed, offset stepped
	logic [7:0] last_val;   // Byte read on the previous even cycle
	logic [8:0] next_off;   // Offset plus carry out

	assign next_off = {1'b0, src.part.offset} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_pend  <= 1'b0;
		end else if (cpu_ce) begin
			// Sample DMA only lines up behind a CPU read on an even cycle
			if (!dmc_pend && dmc_trigger && cpu_rnw && !odd_cycle)
				dmc_pend <= 1'b1;
			if (dmc_pend && !odd_cycle)
				dmc_pend <= 1'b0; // Stolen cycle done
			if (sprite_start)
				spr_state <= SPR_PEND;
			if (spr_state == SPR_PEND && cpu_rnw && odd_cycle)
				spr_state <= SPR_RUN; // First read lands on the following even cycle
			if (spr_state == SPR_RUN && !odd_cycle && dmc_pend)
				spr_state <= SPR_PEND; // Read lost to sample DMA, redo it
			if (spr_state == SPR_RUN && odd_cycle && next_off[8])
				spr_state <= SPR_IDLE; // Write of offset 0xFF was the last
		end
	end

	// Source address and read latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_start) begin
				src.part.page   <= cpu_dout;
				src.part.offset <= 8'h00;
			end else if (spr_state == SPR_RUN && odd_cycle) begin
				src.part.offset <= next_off[7:0];
			end
			if (spr_state == SPR_RUN && !odd_cycle)
				last_val <= ram_data;
		end
	end

	assign dmc_ack    = dmc_pend && !odd_cycle;
	assign dma_enable = dmc_ack || spr_state[1];
	assign dma_read   = !odd_cycle; // Even read, odd write
	assign dma_data   = last_val;
	assign pause_cpu  = spr_state[0] || dmc_trigger;

	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (!odd_cycle)
			dma_addr = src.word;
		else
			dma_addr = OAM_DATA_REG;
	end

endmodule

//--- design/clock_enables.sv
`timescale 1ns/1ps

module clock_enables import nes_bus_pkg::*; #(
	parameter int CPU_DIV = DEFAULT_CPU_DIV,
	parameter int PPU_DIV = DEFAULT_PPU_DIV
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] sys_type,       // Bit 0 selects PAL
	output logic       cpu_ce,         // One clock per CPU cycle
	output logic       ppu_ce,         // One clock per picture unit dot
	output logic       odd_cycle,      // 1 on odd CPU cycles
	output logic       ppu_slot_read,  // Picture unit read tick
	output logic       ppu_slot_write, // Picture unit write tick
	output logic       cpu_reset       // Held until first CPU tick
);
	localparam int CW = $clog2(CPU_DIV + 1);
	localparam int PW = $clog2(PPU_DIV + 1);

	logic [CW-1:0] div_cpu;       // Counts 1..CPU_DIV
	logic [PW-1:0] div_ppu;       // Counts 1..PPU_DIV
	logic [1:0]    ppu_tick;      // Dot index within the CPU cycle
	logic [2:0]    pal_count;     // PAL five cycle counter
	logic [1:0]    last_sys_type;
	logic          hold_reset;
	logic          stretch;       // This CPU cycle gets one extra dot

	assign cpu_ce  = (div_cpu == CW'(CPU_DIV));
	assign ppu_ce  = (div_ppu == PW'(PPU_DIV));
	assign stretch = sys_type[0] && (pal_count == 3'd4);

	// Slots shift by one dot in a stretched cycle
	assign ppu_slot_read  = (ppu_tick == (stretch ? 2'd2 : 2'd1));
	assign ppu_slot_write = (ppu_tick == (stretch ? 2'd1 : 2'd0));
	assign cpu_reset      = hold_reset;

	always_ff @(posedge clk) begin
		last_sys_type <= sys_type;
		if (reset || last_sys_type != sys_type) begin
			// Realign both dividers to a common start
			div_cpu   <= CW'(1);
			div_ppu   <= PW'(1);
			ppu_tick  <= 2'd0;
			pal_count <= 3'd0;
		end else begin
			// CPU divider frozen for the first dot of the stretched cycle
			if (!(stretch && ppu_tick == 2'd0))
				div_cpu <= cpu_ce ? CW'(1) : div_cpu + 1'b1;
			div_ppu <= ppu_ce ? PW'(1) : div_ppu + 1'b1;
			if (cpu_ce)
				ppu_tick <= 2'd0; // Restart dot index with the CPU cycle
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 2'd1;
			if (cpu_ce && sys_type[0])
				pal_count <= (pal_count == 3'd4) ? 3'd0 : pal_count + 3'd1;
		end
	end

	// Cycle parity and CPU reset hold
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle  <= 1'b1;
			hold_reset <= 1'b1;
		end else if (cpu_ce) begin
			odd_cycle  <= ~odd_cycle;
			hold_reset <= 1'b0; // Drops on the clock after the first tick
		end
	end

endmodule

//--- design/nes_bus_pkg.sv
package nes_bus_pkg;

	// CPU-visible register addresses
	localparam logic [15:0] SPRITE_DMA_REG = 16'h4014; // Write starts sprite DMA
	localparam logic [15:0] OAM_DATA_REG   = 16'h2004; // Sprite DMA write target
	localparam logic [15:0] JOY1_REG       = 16'h4016; // Joypad 1, strobe latch on write
	localparam logic [15:0] JOY2_REG       = 16'h4017; // Joypad 2
	localparam logic [15:0] APU_STATUS_REG = 16'h4015; // Only readable audio register

	// Picture unit window, upper bound exclusive
	localparam logic [15:0] PPU_LO = 16'h2000;
	localparam logic [15:0] PPU_HI = 16'h4000;

	// Audio and IO window
	localparam logic [15:0] APU_LO = 16'h4000;
	localparam logic [15:0] APU_HI = 16'h4018;

	// Master clock dividers
	// CPU divider must stay three times the PPU divider
	localparam int DEFAULT_CPU_DIV = 12;
	localparam int DEFAULT_PPU_DIV = 4;

	// Page and offset view of a bus address
	typedef struct packed {
		logic [7:0] page;   // High byte
		logic [7:0] offset; // Low byte
	} bus_addr_s;

	// Sprite DMA steps the offset only, the decoder looks at the full word
	typedef union packed {
		logic [15:0] word;
		bus_addr_s   part;
	} bus_addr_u;

endpackage
